// ==== src/dm_pkg.sv ====
package dm_pkg;

  // ------------------------------
  // register map and DMI encodings
  // ------------------------------

  typedef enum logic [6:0] {
    Data0        = 7'h04,
    DMControl    = 7'h10,
    DMStatus     = 7'h11,
    AbstractCS   = 7'h16,
    Command      = 7'h17,
    AbstractAuto = 7'h18,
    ProgBuf0     = 7'h20,
    HaltSum0     = 7'h40
  } dm_csr_e;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  // codes above busy come from the hart unchanged
  typedef enum logic [2:0] {
    CmdErrNone         = 3'h0,
    CmdErrBusy         = 3'h1,
    CmdErrNotSupported = 3'h2,
    CmdErrException    = 3'h3,
    CmdErrHaltResume   = 3'h4,
    CmdErrBus          = 3'h5,
    CmdErrOther        = 3'h7
  } cmderr_e;

  localparam logic [3:0] DbgVersion013 = 4'h2;

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dtm_op_e     op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dtm_resp_e   resp;
  } dmi_resp_t;

  // ------------------------------
  // register layouts
  // ------------------------------

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       devtreeaddrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [15:0] autoexecprogbuf;
    logic [3:0]  zero0;
    logic [11:0] autoexecdata;
  } abstractauto_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  // ------------------------------
  // internal access and reply
  // ------------------------------

  typedef struct packed {
    logic        rd;
    logic        wr;
    dm_csr_e     addr;
    logic [3:0]  idx;
    logic [31:0] wdata;
  } dm_access_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        busy;
    logic        hit;
  } dm_reply_t;

endpackage

// ==== src/dm_dmi_frontend.sv ====
module dm_dmi_frontend import dm_pkg::*; (
  input  logic       req_valid_i,
  input  logic       req_ready_i,
  input  dmi_req_t   req_i,
  output dm_access_t access_o,
  input  dm_reply_t  hart_reply_i,
  input  dm_reply_t  abs_reply_i,
  output dmi_resp_t  entry_o
);

  logic    accept;
  dtm_op_e op;

  assign accept = req_valid_i & req_ready_i;
  assign op     = req_i.op;

  // ------------------------------
  // request decode
  // ------------------------------

  always_comb begin
    access_o       = '0;
    access_o.rd    = accept & (op == DTM_READ);
    access_o.wr    = accept & (op == DTM_WRITE);
    access_o.addr  = dm_csr_e'(req_i.addr);
    access_o.wdata = req_i.data;
    // data words start at 0x04, progbuf words at 0x20
    if (req_i.addr[6:4] == 3'b000) begin
      access_o.idx = req_i.addr[3:0] - 4'd4;
    end else begin
      access_o.idx = req_i.addr[3:0];
    end
  end

  // ------------------------------
  // reply merge
  // ------------------------------

  always_comb begin
    entry_o.data = 32'h0;
    entry_o.resp = DTM_SUCCESS;
    if (hart_reply_i.hit) begin
      entry_o.data = hart_reply_i.rdata;
      if (hart_reply_i.busy) begin
        entry_o.resp = DTM_BUSY;
      end
    end else if (abs_reply_i.hit) begin
      entry_o.data = abs_reply_i.rdata;
      if (abs_reply_i.busy) begin
        entry_o.resp = DTM_BUSY;
      end
    end
  end

endmodule

// ==== src/dm_resp_fifo.sv ====
module dm_resp_fifo import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wvalid_i,
  output logic      wready_o,
  input  dmi_resp_t wdata_i,
  output logic      rvalid_o,
  input  logic      rready_i,
  output dmi_resp_t rdata_o
);

  dmi_resp_t  mem [2];
  logic       wptr_q, rptr_q;
  logic [1:0] count_q;
  logic       push, pop;

  assign wready_o = (count_q != 2'd2);
  assign rvalid_o = (count_q != 2'd0);
  assign rdata_o  = mem[rptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (push) begin
        wptr_q <= ~wptr_q;
      end
      if (pop) begin
        rptr_q <= ~rptr_q;
      end
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

// ==== src/dm_hart_ctrl.sv ====
module dm_hart_ctrl import dm_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dm_access_t         access_i,
  output dm_reply_t          reply_o,
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] unavailable_i,
  input  logic [NrHarts-1:0] resumeack_i,
  output logic [19:0]        hartsel_o,
  output logic [NrHarts-1:0] haltreq_o,
  output logic [NrHarts-1:0] resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o
);

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  dmcontrol_t         ctrl_wdata;
  dmstatus_t          dmstatus;
  logic [31:0]        haltsum0;
  logic [NrHarts-1:0] havereset_d, havereset_q;
  logic [NrHarts-1:0] hart_sel_oh;
  logic               ctrl_wr;
  logic               sel_halted, sel_unavail, sel_exists;

  assign hartsel_o  = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign ctrl_wr    = access_i.wr & (access_i.addr == DMControl);
  assign ctrl_wdata = dmcontrol_t'(access_i.wdata);

  // one-hot of the selected hart, all zero when out of range
  always_comb begin
    for (int unsigned h = 0; h < NrHarts; h++) begin
      hart_sel_oh[h] = (hartsel_o == 20'(h));
    end
  end

  assign sel_exists  = |hart_sel_oh;
  assign sel_halted  = |(halted_i & hart_sel_oh);
  assign sel_unavail = |(unavailable_i & hart_sel_oh);

  assign haltreq_o   = hart_sel_oh & {NrHarts{dmcontrol_q.haltreq}};
  assign resumereq_o = hart_sel_oh & {NrHarts{dmcontrol_q.resumereq}};
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;

  assign clear_resumeack_o = ctrl_wr & dmcontrol_q.dmactive & ctrl_wdata.resumereq &
                             ~dmcontrol_q.resumereq;

  // ------------------------------
  // dmcontrol and havereset update
  // ------------------------------

  always_comb begin
    dmcontrol_d = dmcontrol_q;
    havereset_d = havereset_q;
    if (ctrl_wr) begin
      dmcontrol_d = ctrl_wdata;
    end
    if (dmcontrol_q.resumereq && |(resumeack_i & hart_sel_oh)) begin
      dmcontrol_d.resumereq = 1'b0;
    end
    // no hart reset, hart arrays or halt-on-reset
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.zero0           = '0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;
    // inactive module keeps only dmactive
    if (!dmcontrol_q.dmactive) begin
      dmcontrol_d          = '0;
      dmcontrol_d.dmactive = ctrl_wr & ctrl_wdata.dmactive;
    end else if (!dmcontrol_d.dmactive) begin
      dmcontrol_d = '0;
    end

    if (ctrl_wr && dmcontrol_q.dmactive && ctrl_wdata.ackhavereset) begin
      havereset_d = havereset_q & ~hart_sel_oh;
    end
    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  // ------------------------------
  // status read back
  // ------------------------------

  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = DbgVersion013;
    dmstatus.authenticated  = 1'b1;
    dmstatus.allhavereset   = |(havereset_q & hart_sel_oh);
    dmstatus.anyhavereset   = |(havereset_q & hart_sel_oh);
    dmstatus.allresumeack   = |(resumeack_i & hart_sel_oh);
    dmstatus.anyresumeack   = |(resumeack_i & hart_sel_oh);
    dmstatus.allnonexistent = ~sel_exists;
    dmstatus.anynonexistent = ~sel_exists;
    dmstatus.allunavail     = sel_unavail;
    dmstatus.anyunavail     = sel_unavail;
    // halted and running exclude unavailable
    dmstatus.allhalted      = sel_halted & ~sel_unavail;
    dmstatus.anyhalted      = sel_halted & ~sel_unavail;
    dmstatus.allrunning     = sel_exists & ~sel_halted & ~sel_unavail;
    dmstatus.anyrunning     = sel_exists & ~sel_halted & ~sel_unavail;
  end

  assign haltsum0 = (hartsel_o[19:5] == 15'd0) ? 32'(halted_i) : 32'h0;

  always_comb begin
    reply_o = '0;
    case (access_i.addr)
      DMControl, DMStatus, HaltSum0: reply_o.hit = access_i.rd | access_i.wr;
      default: reply_o.hit = 1'b0;
    endcase
    if (access_i.rd) begin
      case (access_i.addr)
        DMControl: reply_o.rdata = dmcontrol_q;
        DMStatus:  reply_o.rdata = dmstatus;
        HaltSum0:  reply_o.rdata = haltsum0;
        default:   reply_o.rdata = 32'h0;
      endcase
    end
  end

endmodule

// ==== src/dm_abstract_regs.sv ====
module dm_abstract_regs import dm_pkg::*; #(
  parameter int unsigned DataCount   = 2,
  parameter int unsigned ProgBufSize = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         dmactive_i,
  input  dm_access_t                   access_i,
  output dm_reply_t                    reply_o,
  input  logic                         cmdbusy_i,
  input  logic                         cmderror_valid_i,
  input  cmderr_e                      cmderror_i,
  input  logic [DataCount-1:0][31:0]   data_i,
  input  logic                         data_valid_i,
  output logic                         cmd_valid_o,
  output command_t                     cmd_o,
  output logic [ProgBufSize-1:0][31:0] progbuf_o,
  output logic [DataCount-1:0][31:0]   data_o
);

  localparam int unsigned DataIdxW = (DataCount > 1) ? $clog2(DataCount) : 1;
  localparam int unsigned ProgIdxW = (ProgBufSize > 1) ? $clog2(ProgBufSize) : 1;
  localparam logic [11:0] DataMask = 12'((33'd1 << DataCount) - 33'd1);
  localparam logic [15:0] ProgMask = 16'((33'd1 << ProgBufSize) - 33'd1);

  cmderr_e                      cmderr_d, cmderr_q;
  command_t                     command_d, command_q;
  logic                         cmd_valid_d, cmd_valid_q;
  abstractauto_t                auto_d, auto_q;
  logic [ProgBufSize-1:0][31:0] progbuf_d, progbuf_q;
  logic [DataCount-1:0][31:0]   data_d, data_q;
  abstractcs_t                  abstractcs, cs_wdata;
  logic                         any_access, is_data, is_prog, guarded;

  assign any_access = access_i.rd | access_i.wr;
  assign is_data    = (access_i.addr[6:4] == 3'b000) && (32'(access_i.idx) < DataCount);
  assign is_prog    = (access_i.addr[6:4] == 3'b010) && (32'(access_i.idx) < ProgBufSize);
  assign cs_wdata   = abstractcs_t'(access_i.wdata);

  // accesses refused while a command runs
  assign guarded = is_data | is_prog | (access_i.addr == Command) |
                   (access_i.wr & (access_i.addr == AbstractCS)) |
                   (access_i.wr & (access_i.addr == AbstractAuto));

  always_comb begin
    abstractcs             = '0;
    abstractcs.progbufsize = 5'(ProgBufSize);
    abstractcs.datacount   = 4'(DataCount);
    abstractcs.busy        = cmdbusy_i;
    abstractcs.cmderr      = cmderr_q;
  end

  // ------------------------------
  // register access
  // ------------------------------

  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    auto_d      = auto_q;
    progbuf_d   = progbuf_q;
    data_d      = data_q;
    reply_o     = '0;
    reply_o.hit = any_access & (is_data | is_prog | (access_i.addr == AbstractCS) |
                  (access_i.addr == Command) | (access_i.addr == AbstractAuto));

    if (any_access && guarded && cmdbusy_i) begin
      reply_o.busy = 1'b1;
      if (cmderr_q == CmdErrNone) begin
        cmderr_d = CmdErrBusy;
      end
    end else if (any_access) begin
      if (is_data) begin
        if (access_i.rd) begin
          reply_o.rdata = data_q[access_i.idx[DataIdxW-1:0]];
        end else begin
          data_d[access_i.idx[DataIdxW-1:0]] = access_i.wdata;
        end
        cmd_valid_d = auto_q.autoexecdata[access_i.idx];
      end else if (is_prog) begin
        if (access_i.rd) begin
          reply_o.rdata = progbuf_q[access_i.idx[ProgIdxW-1:0]];
        end else begin
          progbuf_d[access_i.idx[ProgIdxW-1:0]] = access_i.wdata;
        end
        cmd_valid_d = auto_q.autoexecprogbuf[access_i.idx];
      end else begin
        case (access_i.addr)
          AbstractCS: begin
            if (access_i.rd) begin
              reply_o.rdata = abstractcs;
            end else begin
              // write one to clear
              cmderr_d = cmderr_e'(cmderr_q & ~cs_wdata.cmderr);
            end
          end
          Command: begin
            if (access_i.wr) begin
              command_d   = command_t'(access_i.wdata);
              cmd_valid_d = 1'b1;
            end
          end
          AbstractAuto: begin
            if (access_i.rd) begin
              reply_o.rdata = auto_q;
            end else begin
              auto_d                 = '0;
              auto_d.autoexecdata    = access_i.wdata[11:0] & DataMask;
              auto_d.autoexecprogbuf = access_i.wdata[31:16] & ProgMask;
            end
          end
          default: ;
        endcase
      end
    end

    // hart side takes precedence
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      auto_q      <= '0;
      progbuf_q   <= '0;
      data_q      <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      auto_q      <= '0;
      progbuf_q   <= '0;
      data_q      <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      auto_q      <= auto_d;
      progbuf_q   <= progbuf_d;
      data_q      <= data_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign progbuf_o   = progbuf_q;
  assign data_o      = data_q;

endmodule

// ==== src/dm_csrs.sv ====
module dm_csrs import dm_pkg::*; #(
  parameter int unsigned NrHarts     = 4,
  parameter int unsigned DataCount   = 2,
  parameter int unsigned ProgBufSize = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         dmi_req_valid_i,
  output logic                         dmi_req_ready_o,
  input  dmi_req_t                     dmi_req_i,
  output logic                         dmi_resp_valid_o,
  input  logic                         dmi_resp_ready_i,
  output dmi_resp_t                    dmi_resp_o,
  output logic                         ndmreset_o,
  output logic                         dmactive_o,
  input  logic [NrHarts-1:0]           halted_i,
  input  logic [NrHarts-1:0]           unavailable_i,
  input  logic [NrHarts-1:0]           resumeack_i,
  output logic [19:0]                  hartsel_o,
  output logic [NrHarts-1:0]           haltreq_o,
  output logic [NrHarts-1:0]           resumereq_o,
  output logic                         clear_resumeack_o,
  output logic                         cmd_valid_o,
  output command_t                     cmd_o,
  input  logic                         cmderror_valid_i,
  input  cmderr_e                      cmderror_i,
  input  logic                         cmdbusy_i,
  output logic [ProgBufSize-1:0][31:0] progbuf_o,
  output logic [DataCount-1:0][31:0]   data_o,
  input  logic [DataCount-1:0][31:0]   data_i,
  input  logic                         data_valid_i
);

  dm_access_t access;
  dm_reply_t  hart_reply, abs_reply;
  dmi_resp_t  entry;

  dm_dmi_frontend i_frontend (
    .req_valid_i  (dmi_req_valid_i),
    .req_ready_i  (dmi_req_ready_o),
    .req_i        (dmi_req_i),
    .access_o     (access),
    .hart_reply_i (hart_reply),
    .abs_reply_i  (abs_reply),
    .entry_o      (entry)
  );

  // one entry per accepted request
  dm_resp_fifo i_resp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (dmi_req_valid_i),
    .wready_o (dmi_req_ready_o),
    .wdata_i  (entry),
    .rvalid_o (dmi_resp_valid_o),
    .rready_i (dmi_resp_ready_i),
    .rdata_o  (dmi_resp_o)
  );

  dm_hart_ctrl #(
    .NrHarts (NrHarts)
  ) i_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .access_i          (access),
    .reply_o           (hart_reply),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .hartsel_o         (hartsel_o),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_regs #(
    .DataCount   (DataCount),
    .ProgBufSize (ProgBufSize)
  ) i_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmactive_i       (dmactive_o),
    .access_i         (access),
    .reply_o          (abs_reply),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_i           (data_i),
    .data_valid_i     (data_valid_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .progbuf_o        (progbuf_o),
    .data_o           (data_o)
  );

endmodule

// ==== testbench/tb_dm_tasks.svh ====
`ifndef TB_DM_TASKS_SVH
`define TB_DM_TASKS_SVH

localparam logic [31:0] LfsrPoly  = 32'h80200003;
localparam logic [31:0] AbsCsIdle = 32'h0800_0002;

dmi_resp_t   exp_q [$];
logic [31:0] lfsr = 32'habb138fe;
logic [31:0] data_exp [2];
logic [31:0] prog_exp [8];

// one LFSR step per bit taken
function automatic logic [31:0] random_word();
  logic [31:0] w;
  w = '0;
  for (int i = 0; i < 32; i++) begin
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrPoly) : (lfsr >> 1);
    w    = {w[30:0], lfsr[0]};
  end
  return w;
endfunction

// dmcontrol word with the fields used here
function automatic logic [31:0] ctrl_word(input logic halt, input logic resume,
                                          input logic ack, input logic [9:0] sel,
                                          input logic ndm, input logic active);
  logic [31:0] w;
  w        = '0;
  w[31]    = halt;
  w[30]    = resume;
  w[28]    = ack;
  w[25:16] = sel;
  w[1]     = ndm;
  w[0]     = active;
  return w;
endfunction

// dmstatus for a single selected hart
function automatic logic [31:0] status_word(input logic exists, input logic halted,
                                            input logic unavail, input logic hr,
                                            input logic ack);
  logic [31:0] s;
  logic        run;
  run      = exists & ~halted & ~unavail;
  s        = '0;
  s[3:0]   = 4'd2;
  s[7]     = 1'b1;
  s[9:8]   = {2{halted & ~unavail}};
  s[11:10] = {2{run}};
  s[13:12] = {2{unavail}};
  s[15:14] = {2{~exists}};
  s[17:16] = {2{ack}};
  s[19:18] = {2{hr}};
  return s;
endfunction

task automatic dmi_request(input logic [6:0] addr, input dtm_op_e op,
                           input logic [31:0] wdata, input logic [31:0] exp_data,
                           input dtm_resp_e exp_resp);
  @(posedge clk_i);
  dmi_req_valid_i <= 1'b1;
  dmi_req_i       <= '{addr: addr, data: wdata, op: op};
  @(negedge clk_i);
  while (!dmi_req_ready_o) begin
    @(negedge clk_i);
  end
  exp_q.push_back('{data: exp_data, resp: exp_resp});
  @(posedge clk_i);
  dmi_req_valid_i <= 1'b0;
endtask

task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata);
  dmi_request(addr, DTM_WRITE, wdata, 32'h0, DTM_SUCCESS);
endtask

task automatic dmi_read(input logic [6:0] addr, input logic [31:0] exp_data);
  dmi_request(addr, DTM_READ, 32'h0, exp_data, DTM_SUCCESS);
endtask

task automatic check_true(input logic cond, input string what);
  checks++;
  assert (cond) else begin
    errors++;
    $display("MISMATCH at %0t: %s", $time, what);
  end
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  @(negedge clk_i);
endtask

`endif

// ==== testbench/tb_dm_csrs.sv ====
module tb_dm_csrs import dm_pkg::*; ();

  localparam int RequestCount = 58;
  localparam int Timeout      = 20 * RequestCount * 10 + 2000;

  logic                clk_i, rst_ni;
  logic                dmi_req_valid_i, dmi_req_ready_o;
  dmi_req_t            dmi_req_i;
  logic                dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_resp_t           dmi_resp_o;
  logic                ndmreset_o, dmactive_o;
  logic [3:0]          halted_i, unavailable_i, resumeack_i;
  logic [19:0]         hartsel_o;
  logic [3:0]          haltreq_o, resumereq_o;
  logic                clear_resumeack_o, cmd_valid_o;
  command_t            cmd_o;
  logic                cmderror_valid_i, cmdbusy_i, data_valid_i;
  cmderr_e             cmderror_i;
  logic [7:0][31:0]    progbuf_o;
  logic [1:0][31:0]    data_o, data_i;
  int                  errors = 0;
  int                  checks = 0;
  int                  cmd_pulses = 0;
  int                  clr_pulses = 0;

  `include "tb_dm_tasks.svh"

  dm_csrs #(
    .NrHarts     (4),
    .DataCount   (2),
    .ProgBufSize (8)
  ) i_dm_csrs (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // sideband pulse counters
  always @(posedge clk_i) begin
    if (cmd_valid_o) begin
      cmd_pulses++;
    end
    if (clear_resumeack_o) begin
      clr_pulses++;
    end
  end

  // response checker against the expected queue
  always @(posedge clk_i) begin
    if (rst_ni && dmi_resp_valid_o && dmi_resp_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived at %0t with no request pending", $time);
      end else begin
        checks++;
        assert (dmi_resp_o == exp_q[0]) else begin
          errors++;
          $display("MISMATCH at %0t: response %h, expected %h", $time, dmi_resp_o, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    #(Timeout);
    $display("watchdog expired before all requests were answered");
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    int          p;
    logic [31:0] w;
    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    cmdbusy_i        = 1'b0;
    data_valid_i     = 1'b0;
    data_i           = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_cycles(0);
    check_true(!dmactive_o && !ndmreset_o && dmi_req_ready_o && !dmi_resp_valid_o,
               "DMI side or module state not idle after reset");
    check_true(haltreq_o == 4'b0000 && resumereq_o == 4'b0000 && !cmd_valid_o,
               "hart requests or cmd_valid_o raised after reset");

    // hart control
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd0, 0, 1));
    wait_cycles(0);
    check_true(dmactive_o, "dmactive_o not set by the dmcontrol write");
    dmi_write(DMControl, ctrl_word(1, 0, 0, 10'd2, 0, 1));
    wait_cycles(0);
    check_true(haltreq_o == 4'b0100, "haltreq_o not one-hot at hart 2");
    dmi_read(DMStatus, status_word(1, 0, 0, 1, 0));
    @(posedge clk_i);
    halted_i      <= 4'b0110;
    unavailable_i <= 4'b0100;
    dmi_read(DMStatus, status_word(1, 1, 1, 1, 0));
    @(posedge clk_i);
    unavailable_i <= 4'b0000;
    dmi_read(DMStatus, status_word(1, 1, 0, 1, 0));
    dmi_read(HaltSum0, 32'h6);
    dmi_write(DMControl, ctrl_word(1, 0, 0, 10'd6, 0, 1));
    wait_cycles(0);
    check_true(haltreq_o == 4'b0000, "haltreq_o set for a nonexistent hart");
    check_true(hartsel_o == 20'd6, "hartsel_o differs from the written hart select");
    dmi_read(DMStatus, status_word(0, 0, 0, 0, 0));

    // havereset
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd1, 0, 1));
    dmi_write(DMControl, ctrl_word(0, 0, 1, 10'd1, 0, 1));
    dmi_read(DMStatus, status_word(1, 1, 0, 0, 0));
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd0, 0, 1));
    dmi_read(DMStatus, status_word(1, 0, 0, 1, 0));
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd1, 1, 1));
    wait_cycles(0);
    check_true(ndmreset_o, "ndmreset_o not raised by the dmcontrol write");
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd1, 0, 1));
    wait_cycles(0);
    check_true(!ndmreset_o, "ndmreset_o held after the dmcontrol write");
    dmi_read(DMStatus, status_word(1, 1, 0, 1, 0));

    // resume
    p = clr_pulses;
    dmi_write(DMControl, ctrl_word(0, 1, 0, 10'd1, 0, 1));
    wait_cycles(1);
    check_true(clr_pulses == p + 1, "clear_resumeack_o did not pulse once");
    check_true(resumereq_o == 4'b0010, "resumereq_o not raised for hart 1");
    wait_cycles(3);
    check_true(resumereq_o == 4'b0010, "resumereq_o dropped before resumeack");
    @(posedge clk_i);
    resumeack_i <= 4'b0010;
    wait_cycles(1);
    check_true(resumereq_o == 4'b0000, "resumereq_o held after resumeack");
    @(posedge clk_i);
    resumeack_i <= 4'b0000;

    // abstract command
    w = random_word();
    p = cmd_pulses;
    dmi_write(Command, w);
    wait_cycles(2);
    check_true(cmd_pulses == p + 1, "command write did not give one cmd_valid_o pulse");
    check_true(cmd_o == w, "cmd_o differs from the written command");
    @(posedge clk_i);
    cmdbusy_i <= 1'b1;
    dmi_request(Command, DTM_WRITE, ~w, 32'h0, DTM_BUSY);
    dmi_read(AbstractCS, AbsCsIdle | 32'h1000 | 32'h100);
    wait_cycles(1);
    check_true(cmd_pulses == p + 1, "busy command write pulsed cmd_valid_o");
    check_true(cmd_o == w, "busy command write changed cmd_o");
    @(posedge clk_i);
    cmdbusy_i <= 1'b0;
    dmi_write(AbstractCS, 32'h700);
    dmi_read(AbstractCS, AbsCsIdle);
    @(posedge clk_i);
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= CmdErrException;
    @(posedge clk_i);
    cmderror_valid_i <= 1'b0;
    dmi_read(AbstractCS, AbsCsIdle | 32'h300);
    dmi_write(AbstractCS, 32'h700);

    // data and program buffer
    for (int i = 0; i < 2; i++) begin
      data_exp[i] = random_word();
      dmi_write(7'h04 + 7'(i), data_exp[i]);
    end
    for (int i = 0; i < 8; i++) begin
      prog_exp[i] = random_word();
      dmi_write(7'h20 + 7'(i), prog_exp[i]);
    end
    for (int i = 0; i < 2; i++) begin
      dmi_read(7'h04 + 7'(i), data_exp[i]);
      check_true(data_o[i] == data_exp[i], "data_o word differs");
    end
    for (int i = 0; i < 8; i++) begin
      dmi_read(7'h20 + 7'(i), prog_exp[i]);
      check_true(progbuf_o[i] == prog_exp[i], "progbuf_o word differs");
    end

    // autoexec on data0 and progbuf0
    dmi_write(AbstractAuto, 32'h0001_0001);
    dmi_read(AbstractAuto, 32'h0001_0001);
    p = cmd_pulses;
    dmi_read(Data0, data_exp[0]);
    wait_cycles(2);
    check_true(cmd_pulses == p + 1, "data0 access did not retrigger the command");
    prog_exp[0] = random_word();
    dmi_write(ProgBuf0, prog_exp[0]);
    wait_cycles(2);
    check_true(cmd_pulses == p + 2, "progbuf0 access did not retrigger the command");
    dmi_write(AbstractAuto, 32'h0);

    // hart loads the data words
    @(posedge clk_i);
    data_exp[0]  = random_word();
    data_exp[1]  = random_word();
    data_i       <= {data_exp[1], data_exp[0]};
    data_valid_i <= 1'b1;
    @(posedge clk_i);
    data_valid_i <= 1'b0;
    dmi_read(7'h04, data_exp[0]);
    dmi_read(7'h05, data_exp[1]);

    // back-pressure with a stalled response side
    @(posedge clk_i);
    dmi_resp_ready_i <= 1'b0;
    dmi_read(7'h05, data_exp[1]);
    dmi_read(ProgBuf0, prog_exp[0]);
    fork
      dmi_read(7'h21, prog_exp[1]);
      begin
        wait_cycles(3);
        check_true(!dmi_req_ready_o, "third request accepted with a full FIFO");
        @(posedge clk_i);
        dmi_resp_ready_i <= 1'b1;
      end
    join

    // deactivation clears the module
    dmi_write(DMControl, ctrl_word(1, 0, 0, 10'd1, 0, 1));
    wait_cycles(0);
    check_true(haltreq_o == 4'b0010, "haltreq_o not one-hot at hart 1");
    dmi_write(DMControl, 32'h0);
    wait_cycles(2);
    check_true(!dmactive_o, "dmactive_o held after writing dmactive 0");
    check_true(haltreq_o == 4'b0000, "haltreq_o held with dmactive low");
    check_true(data_o == '0, "data words kept with dmactive low");
    dmi_write(DMControl, ctrl_word(0, 0, 0, 10'd0, 0, 1));
    dmi_read(Data0, 32'h0);

    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    wait_cycles(2);
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+testbench
src/dm_pkg.sv
src/dm_dmi_frontend.sv
src/dm_resp_fifo.sv
src/dm_hart_ctrl.sv
src/dm_abstract_regs.sv
src/dm_csrs.sv
testbench/tb_dm_csrs.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_dm_csrs
FILELIST   ?= compile.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
